//--- src/dtm_cfg.svh
`ifndef DTM_CFG_SVH
`define DTM_CFG_SVH

// --------------------
// TAP geometry
// --------------------

// Instruction register length, 5 bits as in debug spec 0.13
`define DTM_IR_LEN 5

// Device identification
// Version 2, part 0x001a, manufacturer 0x2e1, LSB fixed to 1
`define DTM_IDCODE 32'h2001_a5c3

// --------------------
// DMI geometry
// --------------------

// Address bits of a DMI scan, reported in DTMCS.abits
`define DTM_ABITS 7

// Words in the debug-module register bank
// Must be a power of two no larger than 2**DTM_ABITS
`define DTM_NUM_REGS 16

`endif

//--- src/dtm_pkg.sv
`default_nettype none

`include "dtm_cfg.svh"

package dtm_pkg;

    // --------------------
    // TAP controller
    // --------------------

    // The sixteen IEEE 1149.1 states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET, RUN_TEST_IDLE,
        SELECT_DR_SCAN, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
        SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
    } tap_state_e;

    // Instruction opcodes, anything else acts as BYPASS
    typedef enum logic [`DTM_IR_LEN-1:0] {
        BYPASS0    = 5'h00,
        IDCODE     = 5'h01,
        DTMCS      = 5'h10,
        DMI_ACCESS = 5'h11,
        BYPASS1    = 5'h1f
    } ir_opcode_e;

    // Strobes from the TAP state, selects from the IR
    typedef struct packed {
        logic test_logic_reset;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic sel_idcode;
        logic sel_bypass;
        logic sel_dtmcs;
        logic sel_dmi;
    } tap_ctrl_t;

    // --------------------
    // DMI
    // --------------------

    // Request op encoding
    typedef enum logic [1:0] {
        NOP      = 2'd0,
        READ     = 2'd1,
        WRITE    = 2'd2,
        RESERVED = 2'd3
    } dmi_op_e;

    // Status encoding shares the op field
    localparam dmi_op_e SUCCESS = NOP;
    localparam dmi_op_e FAILED  = WRITE;
    localparam dmi_op_e BUSY    = RESERVED;

    // DTM control and status, bit 31 down to bit 0
    typedef struct packed {
        logic [13:0] zero1;
        logic        dmihardreset;
        logic        dmireset;
        logic        zero0;
        logic [2:0]  idle;
        logic [1:0]  dmistat;
        logic [5:0]  abits;
        logic [3:0]  version;
    } dtmcs_t;

    // Scan layout, op in the low bits so it shifts out first
    typedef struct packed {
        logic [`DTM_ABITS-1:0] addr;
        logic [31:0]           data;
        dmi_op_e               op;
    } dmi_req_t;

    typedef struct packed {
        logic [31:0] data;
        dmi_op_e     resp;
    } dmi_resp_t;

endpackage

`default_nettype wire

//--- src/jtag_tap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_cfg.svh"

module jtag_tap_ctrl (
    input  logic              tck_i,
    input  logic              trst_ni,
    input  logic              tms_i,
    input  logic              td_i,
    // Low bits of the data registers
    input  logic              idcode_tdo_i,
    input  logic              bypass_tdo_i,
    input  logic              dtmcs_tdo_i,
    input  logic              dmi_tdo_i,
    output dtm_pkg::tap_ctrl_t ctrl_o,
    output logic              td_o
);

    import dtm_pkg::*;

    // Fixed Capture-IR pattern, low two bits must be 01
    localparam logic [`DTM_IR_LEN-1:0] IR_CAPTURE = 5'b00101;

    tap_state_e                state_q, state_d;
    logic [`DTM_IR_LEN-1:0]    ir_shift_q;
    ir_opcode_e                ir_q;
    logic                      tdo_mux;

    // --------------------
    // TAP state machine
    // --------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            state_q <= TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Instruction register
    // --------------------

    // Shift stage and held instruction
    // Both fall back to IDCODE in Test-Logic-Reset
    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            ir_shift_q <= IDCODE;
            ir_q       <= IDCODE;
        end else if (state_q == TEST_LOGIC_RESET) begin
            ir_shift_q <= IDCODE;
            ir_q       <= IDCODE;
        end else begin
            case (state_q)
                CAPTURE_IR: ir_shift_q <= IR_CAPTURE;
                // LSB first, new bit enters at the top
                SHIFT_IR:   ir_shift_q <= {td_i, ir_shift_q[`DTM_IR_LEN-1:1]};
                // New instruction active from the edge leaving Update-IR
                UPDATE_IR:  ir_q <= ir_opcode_e'(ir_shift_q);
                default:    ir_shift_q <= ir_shift_q;
            endcase
        end
    end

    // --------------------
    // Strobes and selects
    // --------------------

    always_comb begin
        ctrl_o = '0;
        ctrl_o.test_logic_reset = (state_q == TEST_LOGIC_RESET);
        ctrl_o.capture_dr       = (state_q == CAPTURE_DR);
        ctrl_o.shift_dr         = (state_q == SHIFT_DR);
        ctrl_o.update_dr        = (state_q == UPDATE_DR);
        // Decode of the held instruction
        case (ir_q)
            IDCODE:     ctrl_o.sel_idcode = 1'b1;
            DTMCS:      ctrl_o.sel_dtmcs  = 1'b1;
            DMI_ACCESS: ctrl_o.sel_dmi    = 1'b1;
            // BYPASS0, BYPASS1 and unknown opcodes
            default:    ctrl_o.sel_bypass = 1'b1;
        endcase
    end

    // --------------------
    // TDO output
    // --------------------

    always_comb begin
        if (state_q == SHIFT_IR) begin
            tdo_mux = ir_shift_q[0];
        end else if (ctrl_o.sel_idcode) begin
            tdo_mux = idcode_tdo_i;
        end else if (ctrl_o.sel_dtmcs) begin
            tdo_mux = dtmcs_tdo_i;
        end else if (ctrl_o.sel_dmi) begin
            tdo_mux = dmi_tdo_i;
        end else begin
            tdo_mux = bypass_tdo_i;
        end
    end

    // Launched on the falling edge, sampled by the probe on the rising edge
    always_ff @(negedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            td_o <= 1'b0;
        end else begin
            td_o <= tdo_mux;
        end
    end

endmodule

`default_nettype wire

//--- src/dtm_id_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_cfg.svh"

module dtm_id_regs (
    input  logic               tck_i,
    input  logic               trst_ni,
    input  logic               td_i,
    input  dtm_pkg::tap_ctrl_t ctrl_i,
    // Sticky DMI error from the scan register
    input  logic               dmi_error_i,
    output logic               idcode_tdo_o,
    output logic               bypass_tdo_o,
    output logic               dtmcs_tdo_o,
    output logic               dmi_reset_o
);

    import dtm_pkg::*;

    logic        bypass_q;
    logic [31:0] idcode_q;
    dtmcs_t      dtmcs_q;
    dtmcs_t      dtmcs_capture;
    logic        dmi_reset_q;

    // Capture value of DTMCS
    always_comb begin
        dtmcs_capture         = '0;
        dtmcs_capture.version = 4'd1;
        dtmcs_capture.abits   = 6'(`DTM_ABITS);
        // One Run-Test-Idle cycle is enough, no CDC behind us
        dtmcs_capture.idle    = 3'd1;
        dtmcs_capture.dmistat = dmi_error_i ? FAILED : SUCCESS;
    end

    // --------------------
    // Shift registers
    // --------------------

    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            bypass_q <= 1'b0;
            idcode_q <= `DTM_IDCODE;
            dtmcs_q  <= '0;
        end else if (ctrl_i.test_logic_reset) begin
            bypass_q <= 1'b0;
            idcode_q <= `DTM_IDCODE;
            dtmcs_q  <= '0;
        end else if (ctrl_i.capture_dr) begin
            // Bypass captures a zero per 1149.1
            if (ctrl_i.sel_bypass) bypass_q <= 1'b0;
            if (ctrl_i.sel_idcode) idcode_q <= `DTM_IDCODE;
            if (ctrl_i.sel_dtmcs)  dtmcs_q  <= dtmcs_capture;
        end else if (ctrl_i.shift_dr) begin
            if (ctrl_i.sel_bypass) bypass_q <= td_i;
            if (ctrl_i.sel_idcode) idcode_q <= {td_i, idcode_q[31:1]};
            if (ctrl_i.sel_dtmcs)  dtmcs_q  <= {td_i, dtmcs_q[31:1]};
        end
    end

    // --------------------
    // dmireset pulse
    // --------------------

    // High for the single cycle after an Update-DR of DTMCS
    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            dmi_reset_q <= 1'b0;
        end else begin
            dmi_reset_q <= ctrl_i.update_dr & ctrl_i.sel_dtmcs & dtmcs_q.dmireset;
        end
    end

    assign dmi_reset_o  = dmi_reset_q;
    assign bypass_tdo_o = bypass_q;
    assign idcode_tdo_o = idcode_q[0];
    assign dtmcs_tdo_o  = dtmcs_q[0];

endmodule

`default_nettype wire

//--- src/dmi_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_cfg.svh"

module dmi_shift_reg (
    input  logic                tck_i,
    input  logic                trst_ni,
    input  logic                td_i,
    input  dtm_pkg::tap_ctrl_t  ctrl_i,
    // Clear of the sticky error, from DTMCS.dmireset
    input  logic                dmi_reset_i,
    // Response side of the bank
    input  logic                dmi_resp_valid_i,
    input  dtm_pkg::dmi_resp_t  dmi_resp_i,
    // Request side of the bank
    output logic                dmi_req_valid_o,
    output dtm_pkg::dmi_req_t   dmi_req_o,
    output logic                dmi_error_o,
    output logic                dmi_tdo_o
);

    import dtm_pkg::*;

    localparam int SCAN_W = $bits(dmi_req_t);

    dmi_req_t    scan_q;
    dmi_req_t    scan_capture;
    logic [31:0] resp_data_q;
    logic        error_q;
    logic        dmi_update;
    logic        op_access;
    logic        op_reserved;

    // Update-DR of a DMI scan
    assign dmi_update  = ctrl_i.update_dr & ctrl_i.sel_dmi;
    assign op_access   = (scan_q.op == READ) || (scan_q.op == WRITE);
    assign op_reserved = (scan_q.op == RESERVED);

    // --------------------
    // Scan register
    // --------------------

    // Capture shows last response and the sticky status
    always_comb begin
        scan_capture      = '0;
        scan_capture.data = resp_data_q;
        scan_capture.op   = error_q ? FAILED : SUCCESS;
    end

    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            scan_q <= '0;
        end else if (ctrl_i.sel_dmi) begin
            if (ctrl_i.capture_dr) begin
                scan_q <= scan_capture;
            end else if (ctrl_i.shift_dr) begin
                scan_q <= {td_i, scan_q[SCAN_W-1:1]};
            end
        end
    end

    // Data of the most recent response, shown at the next capture
    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            resp_data_q <= '0;
        end else if (dmi_resp_valid_i) begin
            resp_data_q <= dmi_resp_i.data;
        end
    end

    // --------------------
    // Sticky error
    // --------------------

    // Set by a reserved op or a failed response
    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            error_q <= 1'b0;
        end else if (dmi_reset_i) begin
            error_q <= 1'b0;
        end else if (dmi_update && op_reserved) begin
            error_q <= 1'b1;
        end else if (dmi_resp_valid_i && (dmi_resp_i.resp == FAILED)) begin
            error_q <= 1'b1;
        end
    end

    // Request strobe, dropped while an error is pending
    assign dmi_req_valid_o = dmi_update & op_access & ~error_q;
    assign dmi_req_o       = scan_q;
    assign dmi_error_o     = error_q;
    assign dmi_tdo_o       = scan_q[0];

endmodule

`default_nettype wire

//--- src/dm_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_cfg.svh"

module dm_reg_file (
    input  logic               tck_i,
    input  logic               trst_ni,
    input  logic               req_valid_i,
    input  dtm_pkg::dmi_req_t  req_i,
    output logic               resp_valid_o,
    output dtm_pkg::dmi_resp_t resp_o
);

    import dtm_pkg::*;

    localparam int IDX_W = $clog2(`DTM_NUM_REGS);

    logic [31:0]      mem_q [`DTM_NUM_REGS];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             wr_en;
    dmi_resp_t        resp_d;
    dmi_resp_t        resp_q;
    logic             resp_valid_q;

    // Upper address bits must be zero
    assign idx      = req_i.addr[IDX_W-1:0];
    assign in_range = (req_i.addr[`DTM_ABITS-1:IDX_W] == '0);

    // --------------------
    // Access decode
    // --------------------

    always_comb begin
        resp_d = '{data: '0, resp: FAILED};
        wr_en  = 1'b0;
        if (in_range) begin
            case (req_i.op)
                READ: begin
                    resp_d = '{data: mem_q[idx], resp: SUCCESS};
                end
                // Write echoes the stored data
                WRITE: begin
                    resp_d = '{data: req_i.data, resp: SUCCESS};
                    wr_en  = req_valid_i;
                end
                default: begin
                    resp_d.resp = FAILED;
                end
            endcase
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            for (int i = 0; i < `DTM_NUM_REGS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en) begin
            mem_q[idx] <= req_i.data;
        end
    end

    // Response one cycle after the request
    always_ff @(posedge tck_i or negedge trst_ni) begin
        if (!trst_ni) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge tck_i) begin
        if (req_valid_i) begin
            resp_q <= resp_d;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

endmodule

`default_nettype wire

//--- src/dmi_jtag_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag_top (
    input  logic tck_i,
    input  logic trst_ni,
    input  logic tms_i,
    input  logic td_i,
    output logic td_o
);

    import dtm_pkg::*;

    // TAP strobes and selects
    tap_ctrl_t ctrl;

    // Serial data back to the TDO mux
    logic      idcode_tdo;
    logic      bypass_tdo;
    logic      dtmcs_tdo;
    logic      dmi_tdo;

    // Request and response strobes
    logic      dmi_req_valid;
    dmi_req_t  dmi_req;
    logic      dmi_resp_valid;
    dmi_resp_t dmi_resp;

    // Error loop between scan register and DTMCS
    logic      dmi_error;
    logic      dmi_reset;

    jtag_tap_ctrl jtag_tap_ctrl_i (
        .tck_i        (tck_i),
        .trst_ni      (trst_ni),
        .tms_i        (tms_i),
        .td_i         (td_i),
        .idcode_tdo_i (idcode_tdo),
        .bypass_tdo_i (bypass_tdo),
        .dtmcs_tdo_i  (dtmcs_tdo),
        .dmi_tdo_i    (dmi_tdo),
        .ctrl_o       (ctrl),
        .td_o         (td_o)
    );

    dtm_id_regs dtm_id_regs_i (
        .tck_i        (tck_i),
        .trst_ni      (trst_ni),
        .td_i         (td_i),
        .ctrl_i       (ctrl),
        .dmi_error_i  (dmi_error),
        .idcode_tdo_o (idcode_tdo),
        .bypass_tdo_o (bypass_tdo),
        .dtmcs_tdo_o  (dtmcs_tdo),
        .dmi_reset_o  (dmi_reset)
    );

    dmi_shift_reg dmi_shift_reg_i (
        .tck_i            (tck_i),
        .trst_ni          (trst_ni),
        .td_i             (td_i),
        .ctrl_i           (ctrl),
        .dmi_reset_i      (dmi_reset),
        .dmi_resp_valid_i (dmi_resp_valid),
        .dmi_resp_i       (dmi_resp),
        .dmi_req_valid_o  (dmi_req_valid),
        .dmi_req_o        (dmi_req),
        .dmi_error_o      (dmi_error),
        .dmi_tdo_o        (dmi_tdo)
    );

    dm_reg_file dm_reg_file_i (
        .tck_i        (tck_i),
        .trst_ni      (trst_ni),
        .req_valid_i  (dmi_req_valid),
        .req_i        (dmi_req),
        .resp_valid_o (dmi_resp_valid),
        .resp_o       (dmi_resp)
    );

endmodule

`default_nettype wire

//--- bench/dmi_jtag_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dmi_jtag_asserts (
    input  logic tck_i,
    input  logic trst_ni,
    input  logic tdo_i,
    input  logic req_valid_i,
    input  logic resp_valid_i
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Request strobe lasts one cycle only
    assert property (@(posedge tck_i) disable iff (!trst_ni) req_valid_i |=> !req_valid_i)
        else begin
            $error("dmi_req_valid held for more than one cycle");
            fail_count++;
        end

    // Every request answered on the next cycle
    assert property (@(posedge tck_i) disable iff (!trst_ni) req_valid_i |=> resp_valid_i)
        else begin
            $error("dmi_resp_valid missing one cycle after a request");
            fail_count++;
        end

    // Serial output always driven
    assert property (@(posedge tck_i) disable iff (!trst_ni) !$isunknown(tdo_i))
        else begin
            $error("td_o unknown after reset");
            fail_count++;
        end

endmodule

bind dmi_jtag_top dmi_jtag_asserts dmi_jtag_asserts_i (
    .tck_i        (tck_i),
    .trst_ni      (trst_ni),
    .tdo_i        (td_o),
    .req_valid_i  (dmi_req_valid),
    .resp_valid_i (dmi_resp_valid)
);

`default_nettype wire

//--- bench/dmi_jtag_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtm_cfg.svh"

module dmi_jtag_tb;

    import dtm_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    // One DMI operation and the result it should leave behind
    typedef struct packed {
        dmi_op_e               op;
        logic [`DTM_ABITS-1:0] addr;
        logic [31:0]           wdata;
        logic [31:0]           exp_data;
        dmi_op_e               exp_status;
    } dmi_step_t;

    logic        tck_i;
    logic        trst_ni;
    logic        tms_i;
    logic        td_i;
    logic        td_o;

    dmi_step_t   steps[$];
    int          next_step;
    // Shadow of the register bank
    logic [31:0] model_mem [`DTM_NUM_REGS];
    logic        model_err;
    logic [31:0] model_last;
    // What the next DMI capture should show
    logic [31:0] pend_data;
    dmi_op_e     pend_status;

    dmi_jtag_top dmi_jtag_top_i (
        .tck_i   (tck_i),
        .trst_ni (trst_ni),
        .tms_i   (tms_i),
        .td_i    (td_i),
        .td_o    (td_o)
    );

    initial begin
        tck_i = 1'b0;
        forever #50 tck_i = ~tck_i;
    end

    // Watchdog
    initial begin
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(posedge tck_i);
        end
        $display("Simulation did not finish within %0d TCK cycles", TIMEOUT_CYCLES);
        stop_on_error();
    end

    // --------------------
    // Checks
    // --------------------

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_dtmcs(input string name, input dtmcs_t got, input dtmcs_t exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_status(input string name, input dmi_op_e got, input dmi_op_e exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // DTMCS as debug spec 0.13 describes it for this DTM
    function automatic dtmcs_t dtmcs_expect(input dmi_op_e stat);
        dtmcs_t d;
        d         = '0;
        d.version = 4'd1;
        d.abits   = 6'd7;
        d.idle    = 3'd1;
        d.dmistat = stat;
        return d;
    endfunction

    // --------------------
    // JTAG scans
    // --------------------

    // Drive on this edge and sample td_o at the edge that consumes the drive
    task automatic tap_step(input logic tms, input logic tdi, output logic tdo);
        tms_i <= tms;
        td_i  <= tdi;
        @(posedge tck_i);
        tdo = td_o;
    endtask

    // Run-Test-Idle to Run-Test-Idle
    task automatic ir_scan(input logic [`DTM_IR_LEN-1:0] ir,
                           output logic [`DTM_IR_LEN-1:0] ir_out);
        logic b;
        tap_step(1'b1, 1'b0, b);
        tap_step(1'b1, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
        // Last bit leaves Shift-IR
        for (int i = 0; i < `DTM_IR_LEN; i++) begin
            tap_step(i == `DTM_IR_LEN - 1, ir[i], b);
            ir_out[i] = b;
        end
        tap_step(1'b1, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
    endtask

    task automatic dr_scan(input logic [63:0] din, input int len, output logic [63:0] dout);
        logic b;
        dout = '0;
        tap_step(1'b1, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
        for (int i = 0; i < len; i++) begin
            tap_step(i == len - 1, din[i], b);
            dout[i] = b;
        end
        // Update-DR and back to idle
        tap_step(1'b1, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
    endtask

    // Pattern comes back one bit late behind a zero
    task automatic check_bypass(input logic [`DTM_IR_LEN-1:0] opcode);
        logic [`DTM_IR_LEN-1:0] ir_out;
        logic [63:0]            dout;
        logic [31:0]            pattern;
        pattern = $urandom;
        ir_scan(opcode, ir_out);
        dr_scan({32'h0, pattern}, 33, dout);
        check_word("bypass data", dout[32:1], pattern);
        check_word("bypass capture", {31'h0, dout[0]}, 32'h0);
    endtask

    // --------------------
    // DMI table
    // --------------------

    // Append one step with its expected result from the shadow model
    task automatic add_step(input dmi_op_e op, input int addr);
        dmi_step_t s;
        s.op    = op;
        s.addr  = addr[`DTM_ABITS-1:0];
        s.wdata = $urandom;
        if (model_err || op == NOP) begin
            // No request goes out
        end else if (op == RESERVED) begin
            model_err = 1'b1;
        end else if (addr >= `DTM_NUM_REGS) begin
            model_err  = 1'b1;
            model_last = '0;
        end else if (op == WRITE) begin
            model_mem[addr] = s.wdata;
            model_last      = s.wdata;
        end else begin
            model_last = model_mem[addr];
        end
        s.exp_data   = model_last;
        s.exp_status = model_err ? FAILED : SUCCESS;
        steps.push_back(s);
    endtask

    // Each scan shows the result of the one before it
    task automatic run_steps();
        dmi_req_t    req;
        dmi_req_t    got;
        logic [63:0] dout;
        while (next_step < steps.size()) begin
            req.addr = steps[next_step].addr;
            req.data = steps[next_step].wdata;
            req.op   = steps[next_step].op;
            dr_scan(64'(req), $bits(dmi_req_t), dout);
            got = dmi_req_t'(dout[$bits(dmi_req_t)-1:0]);
            check_word("dmi data", got.data, pend_data);
            check_status("dmi status", got.op, pend_status);
            check_word("dmi addr", 32'(got.addr), 32'h0);
            pend_data   = steps[next_step].exp_data;
            pend_status = steps[next_step].exp_status;
            next_step++;
        end
    endtask

    // dmistat shows the error until a dmireset write
    task automatic clear_sticky_error();
        logic [`DTM_IR_LEN-1:0] ir_out;
        logic [63:0]            dout;
        dtmcs_t                 cmd;
        cmd          = '0;
        cmd.dmireset = 1'b1;
        ir_scan(DTMCS, ir_out);
        dr_scan(64'h0, 32, dout);
        check_dtmcs("dtmcs error", dtmcs_t'(dout[31:0]), dtmcs_expect(FAILED));
        dr_scan(64'(cmd), 32, dout);
        check_dtmcs("dtmcs dmireset", dtmcs_t'(dout[31:0]), dtmcs_expect(FAILED));
        dr_scan(64'h0, 32, dout);
        check_dtmcs("dtmcs cleared", dtmcs_t'(dout[31:0]), dtmcs_expect(SUCCESS));
        model_err   = 1'b0;
        pend_status = SUCCESS;
        ir_scan(DMI_ACCESS, ir_out);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic                   b;
        logic [63:0]            dout;
        logic [`DTM_IR_LEN-1:0] ir_out;
        void'($urandom(32'hef53));
        trst_ni  = 1'b0;
        tms_i    = 1'b1;
        td_i     = 1'b0;
        for (int i = 0; i < `DTM_NUM_REGS; i++) begin
            model_mem[i] = '0;
        end
        model_err   = 1'b0;
        model_last  = '0;
        pend_data   = '0;
        pend_status = SUCCESS;
        next_step   = 0;
        repeat (5) @(posedge tck_i);
        trst_ni <= 1'b1;
        tap_step(1'b0, 1'b0, b);

        // IDCODE is the reset instruction
        dr_scan(64'h0, 32, dout);
        check_word("idcode", dout[31:0], `DTM_IDCODE);
        ir_scan(IDCODE, ir_out);
        check_word("ir capture", 32'(ir_out), 32'h5);

        check_bypass(BYPASS0);
        check_bypass(5'h0a);

        ir_scan(DTMCS, ir_out);
        dr_scan(64'h0, 32, dout);
        check_dtmcs("dtmcs", dtmcs_t'(dout[31:0]), dtmcs_expect(SUCCESS));

        // Fill the bank and read it back in reverse
        ir_scan(DMI_ACCESS, ir_out);
        for (int a = 0; a < `DTM_NUM_REGS; a++) begin
            add_step(WRITE, a);
        end
        for (int a = `DTM_NUM_REGS - 1; a >= 0; a--) begin
            add_step(READ, a);
        end
        add_step(WRITE, 9);
        add_step(NOP, 0);
        add_step(READ, 9);
        add_step(NOP, 0);
        run_steps();

        // Out of range read and a write dropped while failed
        add_step(READ, 20);
        add_step(WRITE, 5);
        add_step(NOP, 0);
        run_steps();
        clear_sticky_error();
        add_step(READ, 5);
        add_step(RESERVED, 3);
        add_step(WRITE, 3);
        add_step(NOP, 0);
        run_steps();
        clear_sticky_error();
        add_step(READ, 3);
        add_step(NOP, 0);
        run_steps();

        // Five tms-high cycles reach Test-Logic-Reset
        repeat (5) tap_step(1'b1, 1'b0, b);
        tap_step(1'b0, 1'b0, b);
        dr_scan(64'h0, 32, dout);
        check_word("idcode after tap reset", dout[31:0], `DTM_IDCODE);

        if (dmi_jtag_top_i.dmi_jtag_asserts_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Assertion checks failed during the run");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/dtm_pkg.sv
src/jtag_tap_ctrl.sv
src/dtm_id_regs.sv
src/dmi_shift_reg.sv
src/dm_reg_file.sv
src/dmi_jtag_top.sv
bench/dmi_jtag_asserts.sv
bench/dmi_jtag_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := vlog.f
TOP        := dmi_jtag_tb
RTL_TOP    := dmi_jtag_top
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
